// File: logic/cache_cfg_pkg.sv
package cache_cfg_pkg;

    ////////////////////
    // address split

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 2;                            // byte within a word
    localparam int INDEX_W  = 4;                            // set select
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;  // 26 bits

    ////////////////////
    // geometry

    localparam int SETS  = 1 << INDEX_W;   // 16 sets, one word per way
    localparam int WAYS  = 4;
    localparam int WAY_W = 2;

    ////////////////////
    // replacement ages

    localparam int               AGE_W     = 4;
    localparam logic [AGE_W-1:0] AGE_MAX   = AGE_W'(15);  // ages stop here
    localparam logic [AGE_W-1:0] AGE_RESET = AGE_W'(1);

endpackage

// File: logic/sram_bus_pkg.sv
package sram_bus_pkg;

    ////////////////////
    // SRAM-like bus fields

    localparam int DATA_W = 32;
    localparam int SIZE_W = 2;
    localparam int STRB_W = DATA_W / 8;   // byte lanes per word

    // size codes, same on the CPU and memory side
    localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
    localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

    ////////////////////
    // data word

    // one bus word, either whole or split into byte lanes
    // lane 0 holds bits 7:0
    typedef union packed {
        logic [DATA_W-1:0]           word;
        logic [STRB_W-1:0][7:0]      lane;
    } data_word_u;

endpackage

// File: logic/tag_store.sv
`timescale 1ns/1ns

module tag_store (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [cache_cfg_pkg::INDEX_W-1:0] lookup_index,
    input  logic [cache_cfg_pkg::TAG_W-1:0]   lookup_tag,
    input  logic                              fill_en,
    input  logic [cache_cfg_pkg::INDEX_W-1:0] fill_index,
    input  logic [cache_cfg_pkg::TAG_W-1:0]   fill_tag,
    input  logic [cache_cfg_pkg::WAY_W-1:0]   fill_way,
    output logic                              hit,
    output logic [cache_cfg_pkg::WAY_W-1:0]   hit_way
);

    logic [cache_cfg_pkg::WAYS-1:0]  valid [cache_cfg_pkg::SETS];
    logic [cache_cfg_pkg::TAG_W-1:0] tags  [cache_cfg_pkg::SETS][cache_cfg_pkg::WAYS];
    logic [cache_cfg_pkg::WAYS-1:0]  match;

    ////////////////////
    // lookup

    always_comb begin
        for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
            match[w] = valid[lookup_index][w] && (tags[lookup_index][w] == lookup_tag);
        end
    end

    // walk down so the lowest matching way is the one left standing
    always_comb begin
        hit     = |match;
        hit_way = '0;
        for (int w = cache_cfg_pkg::WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = cache_cfg_pkg::WAY_W'(w);
            end
        end
    end

    ////////////////////
    // fill

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_cfg_pkg::SETS; s++) begin
                valid[s] <= '0;                        // whole cache empty
            end
        end else if (fill_en) begin
            valid[fill_index][fill_way] <= 1'b1;
        end
    end

    // tags are meaningless until valid is set
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_index][fill_way] <= fill_tag;
        end
    end

endmodule

// File: logic/data_store.sv
`timescale 1ns/1ns

module data_store (
    input  logic                                clk,
    input  logic [cache_cfg_pkg::INDEX_W-1:0]   rd_index,
    input  logic [cache_cfg_pkg::WAY_W-1:0]     rd_way,
    input  logic                                wr_en,
    input  logic [cache_cfg_pkg::INDEX_W-1:0]   wr_index,
    input  logic [cache_cfg_pkg::WAY_W-1:0]     wr_way,
    input  logic [sram_bus_pkg::STRB_W-1:0]     wr_strb,
    input  sram_bus_pkg::data_word_u            wr_data,
    output sram_bus_pkg::data_word_u            rd_data
);

    // one word per way and set
    sram_bus_pkg::data_word_u mem [cache_cfg_pkg::SETS][cache_cfg_pkg::WAYS];

    ////////////////////
    // write port

    // merge by byte lane, a fill comes in with every strobe set
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < sram_bus_pkg::STRB_W; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_index][wr_way].lane[b] <= wr_data.lane[b];
                end
            end
        end
    end

    ////////////////////
    // read port

    assign rd_data = mem[rd_index][rd_way];   // async read

endmodule

// File: logic/age_replacer.sv
`timescale 1ns/1ns

module age_replacer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              touch_en,
    input  logic [cache_cfg_pkg::INDEX_W-1:0] touch_index,
    input  logic [cache_cfg_pkg::WAY_W-1:0]   touch_way,
    input  logic [cache_cfg_pkg::INDEX_W-1:0] query_index,
    output logic [cache_cfg_pkg::WAY_W-1:0]   victim_way
);

    logic [cache_cfg_pkg::AGE_W-1:0] age    [cache_cfg_pkg::SETS][cache_cfg_pkg::WAYS];
    logic [cache_cfg_pkg::WAY_W-1:0] victim [cache_cfg_pkg::SETS];

    logic [cache_cfg_pkg::AGE_W-1:0] next_age [cache_cfg_pkg::WAYS];
    logic [cache_cfg_pkg::WAY_W-1:0] next_victim;
    logic [cache_cfg_pkg::AGE_W-1:0] best_age;
    logic                            found;

    ////////////////////
    // ages after a touch

    always_comb begin
        for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
            if (cache_cfg_pkg::WAY_W'(w) == touch_way) begin
                next_age[w] = '0;                              // just used
            end else if (age[touch_index][w] == cache_cfg_pkg::AGE_MAX) begin
                next_age[w] = cache_cfg_pkg::AGE_MAX;          // saturate
            end else begin
                next_age[w] = age[touch_index][w] + 1'b1;
            end
        end
    end

    // oldest untouched way, strict compare keeps the lower index on ties
    always_comb begin
        found       = 1'b0;
        best_age    = '0;
        next_victim = '0;
        for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
            if (cache_cfg_pkg::WAY_W'(w) != touch_way &&
                (!found || next_age[w] > best_age)) begin
                found       = 1'b1;
                best_age    = next_age[w];
                next_victim = cache_cfg_pkg::WAY_W'(w);
            end
        end
    end

    ////////////////////
    // state update

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_cfg_pkg::SETS; s++) begin
                for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
                    age[s][w] <= cache_cfg_pkg::AGE_RESET;
                end
                victim[s] <= '0;
            end
        end else if (touch_en) begin
            for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
                age[touch_index][w] <= next_age[w];
            end
            victim[touch_index] <= next_victim;
        end
    end

    assign victim_way = victim[query_index];

endmodule

// File: logic/access_ctrl.sv
`timescale 1ns/1ns

module access_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    // cpu side
    input  logic                              cpu_req,
    input  logic                              cpu_wr,
    input  logic [sram_bus_pkg::SIZE_W-1:0]   cpu_size,
    input  logic [cache_cfg_pkg::ADDR_W-1:0]  cpu_addr,
    input  logic [sram_bus_pkg::DATA_W-1:0]   cpu_wdata,
    output logic [sram_bus_pkg::DATA_W-1:0]   cpu_rdata,
    output logic                              cpu_addr_ok,
    output logic                              cpu_data_ok,
    // memory side
    output logic                              mem_req,
    output logic                              mem_wr,
    output logic [sram_bus_pkg::SIZE_W-1:0]   mem_size,
    output logic [cache_cfg_pkg::ADDR_W-1:0]  mem_addr,
    output logic [sram_bus_pkg::DATA_W-1:0]   mem_wdata,
    input  logic [sram_bus_pkg::DATA_W-1:0]   mem_rdata,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok,
    // cache blocks
    output logic [cache_cfg_pkg::INDEX_W-1:0] lookup_index,
    output logic [cache_cfg_pkg::TAG_W-1:0]   lookup_tag,
    input  logic                              hit,
    input  logic [cache_cfg_pkg::WAY_W-1:0]   hit_way,
    output logic                              fill_en,
    output logic [cache_cfg_pkg::INDEX_W-1:0] fill_index,
    output logic [cache_cfg_pkg::TAG_W-1:0]   fill_tag,
    output logic [cache_cfg_pkg::WAY_W-1:0]   fill_way,
    output logic [cache_cfg_pkg::INDEX_W-1:0] rd_index,
    output logic [cache_cfg_pkg::WAY_W-1:0]   rd_way,
    input  sram_bus_pkg::data_word_u          rd_data,
    output logic                              wr_en,
    output logic [cache_cfg_pkg::INDEX_W-1:0] wr_index,
    output logic [cache_cfg_pkg::WAY_W-1:0]   wr_way,
    output logic [sram_bus_pkg::STRB_W-1:0]   wr_strb,
    output sram_bus_pkg::data_word_u          wr_data,
    output logic                              touch_en,
    output logic [cache_cfg_pkg::INDEX_W-1:0] touch_index,
    output logic [cache_cfg_pkg::WAY_W-1:0]   touch_way,
    output logic [cache_cfg_pkg::INDEX_W-1:0] query_index,
    input  logic [cache_cfg_pkg::WAY_W-1:0]   victim_way
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RM   = 2'd1;   // read miss, fetching
    localparam logic [1:0] ST_WM   = 2'd2;   // write through

    logic [1:0]                        state;
    logic                              addr_taken;   // memory has the address
    logic [cache_cfg_pkg::ADDR_W-1:0]  addr_q;
    logic [sram_bus_pkg::SIZE_W-1:0]   size_q;
    sram_bus_pkg::data_word_u          wdata_q;
    logic                              hit_q;
    logic [cache_cfg_pkg::WAY_W-1:0]   way_q;
    logic [cache_cfg_pkg::INDEX_W-1:0] idx_q;
    logic [sram_bus_pkg::STRB_W-1:0]   byte_mask;
    logic idle, rd_hit, accept, done, fill_fire, upd_fire;

    assign idle   = (state == ST_IDLE);
    assign rd_hit = idle & cpu_req & ~cpu_wr & hit;          // served at once
    assign accept = idle & cpu_req & (cpu_wr | ~hit);        // needs memory
    assign done   = ~idle & mem_data_ok;

    ////////////////////
    // FSM and request latch

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            addr_taken <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: state <= accept ? (cpu_wr ? ST_WM : ST_RM) : ST_IDLE;
                ST_RM, ST_WM: state <= mem_data_ok ? ST_IDLE : state;
                default: state <= ST_IDLE;
            endcase
            if (done) begin
                addr_taken <= 1'b0;
            end else if (mem_req && mem_addr_ok) begin
                addr_taken <= 1'b1;
            end
        end
    end

    // cpu may move on after addr_ok, so keep our own copy
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q       <= cpu_addr;
            size_q       <= cpu_size;
            wdata_q.word <= cpu_wdata;
            hit_q        <= hit;
            way_q        <= hit_way;
        end
    end

    assign idx_q = addr_q[cache_cfg_pkg::OFFSET_W +: cache_cfg_pkg::INDEX_W];

    // lanes touched by a store
    always_comb begin
        case (size_q)
            sram_bus_pkg::SIZE_BYTE: byte_mask = 4'b0001 << addr_q[1:0];
            sram_bus_pkg::SIZE_HALF: byte_mask = addr_q[1] ? 4'b1100 : 4'b0011;
            default:                 byte_mask = 4'b1111;
        endcase
    end

    ////////////////////
    // bus outputs

    assign mem_req   = ~idle & ~addr_taken;
    assign mem_wr    = (state == ST_WM);
    assign mem_size  = mem_wr ? size_q : sram_bus_pkg::SIZE_WORD;  // fills need the full word
    assign mem_addr  = addr_q;
    assign mem_wdata = wdata_q.word;

    assign cpu_addr_ok = rd_hit | (mem_req & mem_addr_ok);
    assign cpu_data_ok = rd_hit | done;
    assign cpu_rdata   = idle ? rd_data.word : mem_rdata;

    ////////////////////
    // cache side

    assign lookup_index = cpu_addr[cache_cfg_pkg::OFFSET_W +: cache_cfg_pkg::INDEX_W];
    assign lookup_tag   = cpu_addr[cache_cfg_pkg::ADDR_W-1 -: cache_cfg_pkg::TAG_W];
    assign rd_index     = lookup_index;
    assign rd_way       = hit_way;

    assign fill_fire = (state == ST_RM) & mem_data_ok;
    assign upd_fire  = (state == ST_WM) & mem_data_ok & hit_q;   // write miss leaves cache alone

    assign fill_en    = fill_fire;
    assign fill_index = idx_q;
    assign fill_tag   = addr_q[cache_cfg_pkg::ADDR_W-1 -: cache_cfg_pkg::TAG_W];
    assign fill_way   = victim_way;

    assign wr_en        = fill_fire | upd_fire;
    assign wr_index     = idx_q;
    assign wr_way       = fill_fire ? victim_way : way_q;
    assign wr_strb      = fill_fire ? '1 : byte_mask;
    assign wr_data.word = fill_fire ? mem_rdata : wdata_q.word;

    assign touch_en    = wr_en;
    assign touch_index = idx_q;
    assign touch_way   = wr_way;
    assign query_index = idx_q;   // victim of the pending set

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
    input  logic                              clk,
    input  logic                              rst,
    // cpu port
    input  logic                              cpu_req,
    input  logic                              cpu_wr,
    input  logic [sram_bus_pkg::SIZE_W-1:0]   cpu_size,
    input  logic [cache_cfg_pkg::ADDR_W-1:0]  cpu_addr,
    input  logic [sram_bus_pkg::DATA_W-1:0]   cpu_wdata,
    output logic [sram_bus_pkg::DATA_W-1:0]   cpu_rdata,
    output logic                              cpu_addr_ok,
    output logic                              cpu_data_ok,
    // memory port
    output logic                              mem_req,
    output logic                              mem_wr,
    output logic [sram_bus_pkg::SIZE_W-1:0]   mem_size,
    output logic [cache_cfg_pkg::ADDR_W-1:0]  mem_addr,
    output logic [sram_bus_pkg::DATA_W-1:0]   mem_wdata,
    input  logic [sram_bus_pkg::DATA_W-1:0]   mem_rdata,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok
);

    logic [cache_cfg_pkg::INDEX_W-1:0] lookup_index, fill_index, rd_index, wr_index;
    logic [cache_cfg_pkg::INDEX_W-1:0] touch_index, query_index;
    logic [cache_cfg_pkg::TAG_W-1:0]   lookup_tag, fill_tag;
    logic [cache_cfg_pkg::WAY_W-1:0]   hit_way, fill_way, rd_way, wr_way;
    logic [cache_cfg_pkg::WAY_W-1:0]   touch_way, victim_way;
    logic [sram_bus_pkg::STRB_W-1:0]   wr_strb;
    sram_bus_pkg::data_word_u          rd_data, wr_data;
    logic hit, fill_en, wr_en, touch_en;

    ////////////////////
    // storage

    tag_store u_tags (
        .clk, .rst, .lookup_index, .lookup_tag,
        .fill_en, .fill_index, .fill_tag, .fill_way,
        .hit, .hit_way
    );

    data_store u_data (
        .clk, .rd_index, .rd_way, .rd_data,
        .wr_en, .wr_index, .wr_way, .wr_strb, .wr_data
    );

    age_replacer u_ages (
        .clk, .rst, .touch_en, .touch_index, .touch_way,
        .query_index, .victim_way
    );

    ////////////////////
    // control

    access_ctrl u_ctrl (
        .clk, .rst,
        .cpu_req, .cpu_wr, .cpu_size, .cpu_addr, .cpu_wdata,
        .cpu_rdata, .cpu_addr_ok, .cpu_data_ok,
        .mem_req, .mem_wr, .mem_size, .mem_addr, .mem_wdata,
        .mem_rdata, .mem_addr_ok, .mem_data_ok,
        .lookup_index, .lookup_tag, .hit, .hit_way,
        .fill_en, .fill_index, .fill_tag, .fill_way,
        .rd_index, .rd_way, .rd_data,
        .wr_en, .wr_index, .wr_way, .wr_strb, .wr_data,
        .touch_en, .touch_index, .touch_way,
        .query_index, .victim_way
    );

endmodule

// File: verif/dcache_props.sv
`timescale 1ns/1ns

module dcache_props (
    input logic                             clk,
    input logic                             rst,
    input logic                             idle,
    input logic                             cpu_req,
    input logic                             cpu_wr,
    input logic                             hit,
    input logic                             cpu_addr_ok,
    input logic                             cpu_data_ok,
    input logic                             mem_req,
    input logic                             mem_wr,
    input logic [sram_bus_pkg::SIZE_W-1:0]  mem_size,
    input logic [cache_cfg_pkg::ADDR_W-1:0] mem_addr,
    input logic [sram_bus_pkg::DATA_W-1:0]  mem_wdata,
    input logic                             mem_addr_ok
);

    logic pending;   // cpu address taken, data not back yet

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (cpu_data_ok) begin
            pending <= 1'b0;
        end else if (cpu_req && cpu_addr_ok) begin
            pending <= 1'b1;
        end
    end

    // request and its fields hold until memory takes the address
    req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_wr) && $stable(mem_size)
            && $stable(mem_addr) && $stable(mem_wdata))
        else $error("memory request dropped or changed before mem_addr_ok");

    // memory request only starts right after an idle accept of a miss or write
    req_after_accept: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req) |-> $past(idle && cpu_req && (cpu_wr || !hit)))
        else $error("memory request raised while no access was accepted");

    data_ok_owned: assert property (@(posedge clk) disable iff (rst)
        cpu_data_ok |-> (cpu_req && cpu_addr_ok) || pending)
        else $error("cpu_data_ok without an accepted request");   // same cycle or pending

endmodule

// File: verif/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;

    localparam int NUM_OPS   = 2000;
    localparam int CYCLE_CAP = NUM_OPS * 12;

    logic                                    clk = 1'b0;
    logic                                    rst;
    logic                                    cpu_req, cpu_wr, cpu_addr_ok, cpu_data_ok;
    logic [sram_bus_pkg::SIZE_W-1:0]         cpu_size, mem_size;
    logic [cache_cfg_pkg::ADDR_W-1:0]        cpu_addr, mem_addr;
    logic [sram_bus_pkg::DATA_W-1:0]         cpu_wdata, cpu_rdata, mem_wdata, mem_rdata;
    logic                                    mem_req, mem_wr, mem_addr_ok, mem_data_ok;

    // reference memory by word address, cache model beside it
    logic [31:0]                             ref_mem [logic [29:0]];
    logic                                    m_valid  [cache_cfg_pkg::SETS][cache_cfg_pkg::WAYS];
    logic [cache_cfg_pkg::TAG_W-1:0]         m_tag    [cache_cfg_pkg::SETS][cache_cfg_pkg::WAYS];
    logic [cache_cfg_pkg::AGE_W-1:0]         m_age    [cache_cfg_pkg::SETS][cache_cfg_pkg::WAYS];
    logic [cache_cfg_pkg::WAY_W-1:0]         m_victim [cache_cfg_pkg::SETS];
    logic [31:0]                             lfsr = 32'h88025376;
    int                                      errors = 0;
    int                                      cycles = 0;

    dcache_top DUT (.*);

    bind access_ctrl dcache_props u_props (
        .clk, .rst, .idle, .cpu_req, .cpu_wr, .hit, .cpu_addr_ok, .cpu_data_ok,
        .mem_req, .mem_wr, .mem_size, .mem_addr, .mem_wdata, .mem_addr_ok
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_CAP) begin
            $display("timeout: %0d operations not done after %0d cycles", NUM_OPS, CYCLE_CAP);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////
    // helpers

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return {addr[15:2], addr[31:14]} ^ 32'hC3A55A3C;   // untouched words
    endfunction

    function automatic logic [3:0] lanes_for(input logic [1:0] size, input logic [1:0] off);
        case (size)
            sram_bus_pkg::SIZE_BYTE: return 4'b0001 << off;
            sram_bus_pkg::SIZE_HALF: return off[1] ? 4'b1100 : 4'b0011;
            default:                 return 4'b1111;
        endcase
    endfunction

    task automatic value_error(input string what, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic protocol_error(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // touched way goes young, the rest age, oldest untouched becomes victim
    task automatic touch_model(input int s, input int w);
        logic                            found;
        logic [cache_cfg_pkg::AGE_W-1:0] best;
        found = 1'b0;
        best  = '0;
        for (int i = 0; i < cache_cfg_pkg::WAYS; i++) begin
            if (i == w) m_age[s][i] = '0;
            else if (m_age[s][i] != cache_cfg_pkg::AGE_MAX) m_age[s][i] = m_age[s][i] + 4'd1;
        end
        for (int i = 0; i < cache_cfg_pkg::WAYS; i++) begin
            if (i != w && (!found || m_age[s][i] > best)) begin
                found       = 1'b1;
                best        = m_age[s][i];
                m_victim[s] = 2'(i);
            end
        end
    endtask

    ////////////////////
    // one CPU access with the memory side answering

    task automatic run_op(input logic wr, input logic [1:0] size, input logic [31:0] addr,
                          input logic [31:0] wdata);
        int          s, hw, v, wait_a, wait_d;
        logic        hit_pred, got_addr;
        logic [31:0] word;
        logic [3:0]  lanes;
        logic [1:0]  exp_size;
        s        = int'(addr[5:2]);
        hit_pred = 1'b0;
        hw       = 0;
        for (int w = cache_cfg_pkg::WAYS - 1; w >= 0; w--) begin
            if (m_valid[s][w] && m_tag[s][w] == addr[31:6]) begin
                hit_pred = 1'b1;
                hw       = w;
            end
        end
        wait_a   = int'(take_bits(2));
        wait_d   = int'(take_bits(2));
        exp_size = wr ? size : sram_bus_pkg::SIZE_WORD;   // a fill fetches the whole word
        @(negedge clk);
        {cpu_req, cpu_wr, cpu_size, cpu_addr, cpu_wdata} = {1'b1, wr, size, addr, wdata};
        {mem_addr_ok, mem_data_ok} = 2'b00;
        #5;
        if (!wr && hit_pred) begin
            if (!cpu_addr_ok || !cpu_data_ok || mem_req) begin
                protocol_error("predicted read hit was not served in the request cycle");
            end else if (cpu_rdata !== mem_read(addr)) begin
                value_error("hit cpu_rdata", cpu_rdata, mem_read(addr));
            end
        end else begin
            if (cpu_addr_ok || cpu_data_ok) protocol_error("miss or write answered at once");
            got_addr = 1'b0;
            do begin
                @(negedge clk);
                if (got_addr) begin   // cpu moves on to lines that may hit
                    cpu_addr  = {26'h0155A00 + 26'(int'(take_bits(3)) % 6),
                                 2'(take_bits(2)), 4'b0100};
                    cpu_wr    = take_bits(1) != 32'd0;
                    cpu_wdata = take_bits(32);
                end
                mem_addr_ok = !got_addr && wait_a == 0;
                mem_data_ok = (got_addr || mem_addr_ok) && wait_d == 0;
                mem_rdata   = wr ? take_bits(32) : mem_read(addr);
                #5;
                if (!got_addr) begin
                    if (!mem_req || mem_wr !== wr) begin
                        protocol_error("memory request missing or of the wrong kind");
                    end else if (mem_addr !== addr) begin
                        value_error("mem_addr", mem_addr, addr);
                    end else if (mem_size !== exp_size) begin
                        value_error("mem_size", 32'(mem_size), 32'(exp_size));
                    end else if (wr && mem_wdata !== wdata) begin
                        value_error("mem_wdata", mem_wdata, wdata);
                    end
                end else if (mem_req) begin
                    protocol_error("memory request raised again after mem_addr_ok");
                end
                if (cpu_addr_ok !== mem_addr_ok) protocol_error("cpu_addr_ok out of step");
                if (cpu_data_ok !== mem_data_ok) protocol_error("cpu_data_ok out of step");
                if (mem_data_ok && !wr && cpu_rdata !== mem_rdata) begin
                    value_error("miss cpu_rdata", cpu_rdata, mem_rdata);
                end
                if (mem_addr_ok) got_addr = 1'b1;
                else if (!got_addr) wait_a--;
                if (got_addr && wait_d > 0) wait_d--;
            end while (!mem_data_ok);
            if (wr) begin
                lanes = lanes_for(size, addr[1:0]);
                word  = mem_read(addr);
                for (int b = 0; b < 4; b++) begin
                    if (lanes[b]) word[8*b +: 8] = wdata[8*b +: 8];
                end
                ref_mem[addr[31:2]] = word;
                if (hit_pred) touch_model(s, hw);   // no allocate on a write miss
            end else begin
                v              = int'(m_victim[s]);
                m_valid[s][v]  = 1'b1;
                m_tag[s][v]    = addr[31:6];
                touch_model(s, v);
            end
        end
    endtask

    ////////////////////
    // stimulus and verdict

    initial begin
        int          t;
        logic        op_wr;
        logic [1:0]  op_size, off, set_sel;
        {cpu_req, cpu_wr, cpu_size, cpu_addr, cpu_wdata} = '0;
        {mem_rdata, mem_addr_ok, mem_data_ok} = '0;
        rst = 1'b1;
        for (int s = 0; s < cache_cfg_pkg::SETS; s++) begin
            for (int w = 0; w < cache_cfg_pkg::WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_age[s][w]   = cache_cfg_pkg::AGE_RESET;
            end
            m_victim[s] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < NUM_OPS; n++) begin
            op_wr   = (take_bits(2) == 32'd0) && (n != 0);   // first access is a read
            op_size = 2'(take_bits(2));
            if (op_size == 2'd3) op_size = sram_bus_pkg::SIZE_WORD;
            off     = 2'(take_bits(2));
            if (op_size == sram_bus_pkg::SIZE_HALF) off[0] = 1'b0;
            if (op_size == sram_bus_pkg::SIZE_WORD) off = 2'b00;
            t       = int'(take_bits(3)) % 6;                 // six tags fight over four ways
            set_sel = 2'(take_bits(2));
            run_op(op_wr, op_size, {26'h0155A00 + 26'(t), set_sel, 2'b01, off}, take_bits(32));
        end
        @(negedge clk);
        {cpu_req, mem_addr_ok, mem_data_ok} = 3'b000;
        repeat (2) @(negedge clk);
        $display("%0d operations, %0d errors", NUM_OPS, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: dcache.f
logic/cache_cfg_pkg.sv
logic/sram_bus_pkg.sv
logic/tag_store.sv
logic/data_store.sv
logic/age_replacer.sv
logic/access_ctrl.sv
logic/dcache_top.sv
verif/dcache_props.sv
verif/dcache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f dcache.f --top-module dcache_tb

status=0
out=$(./obj_dir/Vdcache_tb) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TEST PASSED'; then
    exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1
